// File: Makefile
# Verilator build for the AXI-Lite SRAM slave

TOP      ?= axi_sram_tb
FLIST    ?= axi_sram.f
OBJ_DIR  ?= obj_dir
VFLAGS   ?= --binary --timing --assert -j 0
SIM_ARGS ?=

VERILATOR ?= verilator

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)

// File: axi_sram.f
rtl/axi_sram_pkg.sv
rtl/axi_sram_write_port.sv
rtl/axi_sram_read_port.sv
rtl/sram_rw_arbiter.sv
rtl/sram_controller.sv
rtl/axi_sram_top.sv
bench/sram_chip_model.sv
bench/axi_sram_props.sv
bench/axi_sram_tb.sv

// File: bench/axi_sram_props.sv
`timescale 1ns/1ns

module axi_sram_props (
  input logic                                axi_clk,
  input logic                                axi_resetn,
  input logic                                sram_we_n,
  input logic                                sram_oe_n,
  input logic                                sram_ce_n,
  input logic                                bvalid,
  input logic                                bready,
  input logic [1:0]                          bresp,
  input logic                                rvalid,
  input logic                                rready,
  input logic [1:0]                          rresp,
  input logic [axi_sram_pkg::data_width-1:0] rdata
);

  // write enable and output enable must never overlap
  a_we_oe_excl: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    !(!sram_we_n && !sram_oe_n))
    else $error("we_n and oe_n low together");

  a_ce_active: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    (!sram_we_n || !sram_oe_n) |-> !sram_ce_n)
    else $error("we_n or oe_n low while ce_n is high");

  a_b_hold: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    (bvalid && !bready) |=> (bvalid && $stable(bresp)))
    else $error("write response dropped or changed before bready");

  a_r_hold: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    (rvalid && !rready) |=> (rvalid && $stable(rdata) && $stable(rresp)))
    else $error("read response dropped or changed before rready");

endmodule

// File: bench/axi_sram_tb.sv
`timescale 1ns/1ns

module axi_sram_tb;

  import axi_sram_pkg::*;

  localparam int clk_period  = 20;
  localparam int n_random    = 40;
  localparam int n_fair      = 16;
  localparam int txn_cycles  = 40;
  localparam int n_txn       = 6 + 2 * n_random + 2 * n_fair;
  localparam int watchdog_ns = n_txn * txn_cycles * clk_period;

  logic axi_clk;
  logic axi_resetn;
  logic [addr_width-1:0] awaddr;
  logic awvalid;
  logic awready;
  logic [data_width-1:0] wdata;
  logic [strb_width-1:0] wstrb;
  logic wvalid;
  logic wready;
  logic [1:0] bresp;
  logic bvalid;
  logic bready;
  logic [addr_width-1:0] araddr;
  logic arvalid;
  logic arready;
  logic [data_width-1:0] rdata;
  logic [1:0] rresp;
  logic rvalid;
  logic rready;
  logic [addr_width-1:0] sram_addr;
  wire  [data_width-1:0] sram_data;
  logic sram_we_n;
  logic sram_oe_n;
  logic sram_ce_n;

  // handshake flags set by the monitor and cleared by the driver
  bit aw_hs;
  bit ar_hs;
  bit b_hs;
  bit r_hs;
  logic [15:0] lfsr = 16'd4;
  logic [data_width-1:0] ref_mem [logic [addr_width-1:0]];
  logic [1:0] exp_b[$];
  logic [17:0] exp_r[$];
  logic [addr_width-1:0] pw_addr;
  logic [data_width-1:0] pw_data;
  logic [strb_width-1:0] pw_strb;
  int we_low_cycles;
  bit fair_mode;
  int fair_seen;
  bit last_kind;
  bit ce_prev = 1'b1;

  axi_sram_top dut0 (.*);

  sram_chip_model chip0 (
    .sram_addr (sram_addr),
    .sram_data (sram_data),
    .sram_we_n (sram_we_n),
    .sram_oe_n (sram_oe_n),
    .sram_ce_n (sram_ce_n)
  );

  bind axi_sram_top axi_sram_props props0 (
    .axi_clk (axi_clk), .axi_resetn (axi_resetn),
    .sram_we_n (sram_we_n), .sram_oe_n (sram_oe_n), .sram_ce_n (sram_ce_n),
    .bvalid (bvalid), .bready (bready), .bresp (bresp),
    .rvalid (rvalid), .rready (rready), .rresp (rresp), .rdata (rdata)
  );

  always #(clk_period / 2) axi_clk = ~axi_clk;

  // 16-bit galois lfsr stepped once per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // chip power-up content over the whole address
  function automatic logic [data_width-1:0] initial_word(input logic [addr_width-1:0] a);
    return a[15:0] ^ {a[19:16], a[19:16], a[19:16], a[19:16]} ^ 16'h5a3c;
  endfunction

  // expected {resp, data} taken from the reference memory
  function automatic logic [17:0] ref_response(input bit is_write,
                                               input logic [addr_width-1:0] a,
                                               input logic [strb_width-1:0] strb);
    if (is_write) begin
      return {((strb == 2'b11) ? 2'b00 : 2'b10), 16'h0000};
    end
    return {2'b00, (ref_mem.exists(a) ? ref_mem[a] : initial_word(a))};
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
      fail_run("value mismatch");
    end
  endtask

  task automatic expect_idle();
    check("awready", 32'(awready), 32'h0);
    check("wready", 32'(wready), 32'h0);
    check("arready", 32'(arready), 32'h0);
    check("bvalid", 32'(bvalid), 32'h0);
    check("rvalid", 32'(rvalid), 32'h0);
    check("sram_ce_n", 32'(sram_ce_n), 32'h1);
    check("sram_we_n", 32'(sram_we_n), 32'h1);
    check("sram_oe_n", 32'(sram_oe_n), 32'h1);
  endtask

  // compare process sampling handshakes with pre-edge values
  always @(posedge axi_clk) begin : monitor
    logic [17:0] e;
    bit kind;
    if (axi_resetn) begin
      if (awvalid && awready) begin
        aw_hs = 1'b1;
        pw_addr = awaddr;
        pw_data = wdata;
        pw_strb = wstrb;
        e = ref_response(1'b1, awaddr, wstrb);
        exp_b.push_back(e[17:16]);
      end
      if (arvalid && arready) begin
        ar_hs = 1'b1;
        exp_r.push_back(ref_response(1'b0, araddr, 2'b11));
      end
      if (bvalid && bready) begin
        b_hs = 1'b1;
        if (exp_b.size() == 0) fail_run("write response without a write request");
        check("bresp", 32'(bresp), 32'(exp_b.pop_front()));
        if (pw_strb == 2'b11) ref_mem[pw_addr] = pw_data;
      end
      if (rvalid && rready) begin
        r_hs = 1'b1;
        if (exp_r.size() == 0) fail_run("read response without a read request");
        e = exp_r.pop_front();
        check("rresp", 32'(rresp), 32'(e[17:16]));
        check("rdata", 32'(rdata), 32'(e[15:0]));
      end
      if (!sram_we_n) we_low_cycles++;
      // every access start, the kind of the previous one is kept for the fair check
      if (ce_prev && !sram_ce_n) begin
        kind = !sram_we_n;
        if (fair_mode && fair_seen < 2 * n_fair - 4) begin
          check("access kind (1 = write)", 32'(kind), 32'(!last_kind));
          fair_seen++;
        end
        last_kind = kind;
      end
    end
    ce_prev = sram_ce_n;
  end

  task automatic write_word(input logic [addr_width-1:0] a, input logic [data_width-1:0] d,
                            input logic [strb_width-1:0] s);
    @(negedge axi_clk);
    awaddr = a;
    wdata = d;
    wstrb = s;
    awvalid = 1'b1;
    wvalid = 1'b1;
    bready = 1'b1;
    while (!aw_hs) @(negedge axi_clk);
    aw_hs = 1'b0;
    awvalid = 1'b0;
    wvalid = 1'b0;
    while (!b_hs) @(negedge axi_clk);
    b_hs = 1'b0;
  endtask

  task automatic read_word(input logic [addr_width-1:0] a);
    @(negedge axi_clk);
    araddr = a;
    arvalid = 1'b1;
    rready = 1'b1;
    while (!ar_hs) @(negedge axi_clk);
    ar_hs = 1'b0;
    arvalid = 1'b0;
    while (!r_hs) @(negedge axi_clk);
    r_hs = 1'b0;
  endtask

  // both ports at once with no read and write to one address in flight
  task automatic run_traffic(input int n, input bit fair);
    int w_left;
    int r_left;
    bit w_busy;
    bit r_busy;
    logic [addr_width-1:0] w_a;
    logic [addr_width-1:0] r_a;
    logic [addr_width-1:0] a;
    w_left = n;
    r_left = n;
    w_busy = 1'b0;
    r_busy = 1'b0;
    while (w_left > 0 || r_left > 0 || w_busy || r_busy) begin
      @(negedge axi_clk);
      if (aw_hs) begin
        aw_hs = 1'b0;
        awvalid = 1'b0;
        wvalid = 1'b0;
      end
      if (ar_hs) begin
        ar_hs = 1'b0;
        arvalid = 1'b0;
      end
      if (b_hs) begin
        b_hs = 1'b0;
        w_busy = 1'b0;
      end
      if (r_hs) begin
        r_hs = 1'b0;
        r_busy = 1'b0;
      end
      if (!w_busy && w_left > 0 && (fair || take_bits(1) == 32'h1)) begin
        a = fair ? (addr_width'(take_bits(19)) << 1) : (20'h000a0 + addr_width'(take_bits(3)));
        if (!(r_busy && a == r_a)) begin
          w_busy = 1'b1;
          w_a = a;
          awaddr = a;
          wdata = data_width'(take_bits(16));
          wstrb = (fair || take_bits(2) != 32'h0) ? 2'b11 : strb_width'(take_bits(2));
          awvalid = 1'b1;
          wvalid = 1'b1;
          w_left--;
        end
      end
      if (!r_busy && r_left > 0 && (fair || take_bits(1) == 32'h1)) begin
        a = fair ? ((addr_width'(take_bits(19)) << 1) | 20'h1)
                 : (20'h000a0 + addr_width'(take_bits(3)));
        if (!(w_busy && a == w_a)) begin
          r_busy = 1'b1;
          r_a = a;
          araddr = a;
          arvalid = 1'b1;
          r_left--;
        end
      end
      bready = fair ? 1'b1 : 1'(take_bits(1));
      rready = fair ? 1'b1 : 1'(take_bits(1));
    end
  endtask

  initial begin : watchdog
    #(watchdog_ns);
    fail_run("watchdog expired, a transaction never completed");
  end

  initial begin : main
    logic [data_width-1:0] peeked;
    int we_before;
    axi_clk = 1'b0;
    axi_resetn = 1'b0;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    repeat (4) begin
      @(negedge axi_clk);
      expect_idle();
    end
    axi_resetn = 1'b1;
    @(negedge axi_clk);
    expect_idle();

    // write then read back
    write_word(20'h00123, 16'hbeef, 2'b11);
    chip0.peek(20'h00123, peeked);
    check("sram word 0x00123", 32'(peeked), 32'hbeef);
    read_word(20'h00123);

    // partial strobes never reach the chip
    we_before = we_low_cycles;
    write_word(20'h00123, 16'h1111, 2'b01);
    check("we_n low cycles", 32'(we_low_cycles), 32'(we_before));
    read_word(20'h00123);
    write_word(20'hf0042, 16'h2222, 2'b10);
    read_word(20'hf0042);

    run_traffic(n_random, 1'b0);

    fair_mode = 1'b1;
    run_traffic(n_fair, 1'b1);
    fair_mode = 1'b0;
    check("fair accesses seen", 32'(fair_seen), 32'(2 * n_fair - 4));

    repeat (4) @(negedge axi_clk);
    check("outstanding write responses", 32'(exp_b.size()), 32'h0);
    check("outstanding read responses", 32'(exp_r.size()), 32'h0);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// File: bench/sram_chip_model.sv
`timescale 1ns/1ns

module sram_chip_model (
  input  logic [axi_sram_pkg::addr_width-1:0] sram_addr,
  inout  wire  [axi_sram_pkg::data_width-1:0] sram_data,
  input  logic                                sram_we_n,
  input  logic                                sram_oe_n,
  input  logic                                sram_ce_n
);

  import axi_sram_pkg::*;

  logic [data_width-1:0] mem [logic [addr_width-1:0]];
  logic [data_width-1:0] rd_word;

  // power-up content depends on every address bit
  function automatic logic [data_width-1:0] fill_word(input logic [addr_width-1:0] a);
    return a[15:0] ^ {a[19:16], a[19:16], a[19:16], a[19:16]} ^ 16'h5a3c;
  endfunction

  always @(sram_addr or sram_oe_n or sram_ce_n or sram_we_n) begin
    rd_word = mem.exists(sram_addr) ? mem[sram_addr] : fill_word(sram_addr);
  end

  assign sram_data = (!sram_ce_n && !sram_oe_n && sram_we_n) ? rd_word : 'z;

  // level sensitive write while ce_n and we_n are low
  always @(sram_we_n or sram_ce_n or sram_addr or sram_data) begin
    if (!sram_ce_n && !sram_we_n) begin
      mem[sram_addr] = sram_data;
    end
  end

  task automatic peek(input logic [addr_width-1:0] a, output logic [data_width-1:0] d);
    d = mem.exists(a) ? mem[a] : fill_word(a);
  endtask

endmodule

// File: rtl/axi_sram_pkg.sv
package axi_sram_pkg;

  // bus and chip geometry
  localparam int addr_width = 20;
  localparam int data_width = 16;
  localparam int strb_width = data_width / 8;

  // cycles with we_n or oe_n held low
  localparam int sram_access_cycles = 2;

  // axi response codes
  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  // one sram access as handed from a port to the controller
  typedef struct packed {
    logic                  write;
    logic [addr_width-1:0] addr;
    logic [data_width-1:0] wdata;
  } sram_req_t;

endpackage

// File: rtl/axi_sram_read_port.sv
`timescale 1ns/1ns

module axi_sram_read_port (
  input  logic                                axi_clk,
  input  logic                                axi_resetn,
  input  logic [axi_sram_pkg::addr_width-1:0] araddr,
  input  logic                                arvalid,
  output logic                                arready,
  output logic [axi_sram_pkg::data_width-1:0] rdata,
  output logic [1:0]                          rresp,
  output logic                                rvalid,
  input  logic                                rready,
  output logic                                req,
  output axi_sram_pkg::sram_req_t             req_data,
  input  logic                                grant,
  input  logic                                done,
  input  logic [axi_sram_pkg::data_width-1:0] rdata_in
);

  import axi_sram_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_request,
    st_wait,
    st_respond
  } state_t;

  state_t    state;
  sram_req_t req_q;

  // reads never fail
  assign rresp    = resp_okay;
  assign req      = (state == st_request);
  assign req_data = req_q;

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      state   <= st_idle;
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      arready <= 1'b0;
      case (state)
        st_idle: begin
          if (arready) begin
            state <= st_request;
          end else if (arvalid) begin
            arready <= 1'b1;
          end
        end
        st_request: begin
          if (grant) begin
            state <= st_wait;
          end
        end
        st_wait: begin
          if (done) begin
            state  <= st_respond;
            rvalid <= 1'b1;
          end
        end
        st_respond: begin
          if (rready) begin
            rvalid <= 1'b0;
            state  <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge axi_clk) begin
    if (arready) begin
      req_q.write <= 1'b0;
      req_q.addr  <= araddr;
      req_q.wdata <= '0;
    end
    // held until the next access finishes
    if (state == st_wait && done) begin
      rdata <= rdata_in;
    end
  end

endmodule

// File: rtl/axi_sram_top.sv
`timescale 1ns/1ns

module axi_sram_top (
  input  logic                                axi_clk,
  input  logic                                axi_resetn,
  input  logic [axi_sram_pkg::addr_width-1:0] awaddr,
  input  logic                                awvalid,
  output logic                                awready,
  input  logic [axi_sram_pkg::data_width-1:0] wdata,
  input  logic [axi_sram_pkg::strb_width-1:0] wstrb,
  input  logic                                wvalid,
  output logic                                wready,
  output logic [1:0]                          bresp,
  output logic                                bvalid,
  input  logic                                bready,
  input  logic [axi_sram_pkg::addr_width-1:0] araddr,
  input  logic                                arvalid,
  output logic                                arready,
  output logic [axi_sram_pkg::data_width-1:0] rdata,
  output logic [1:0]                          rresp,
  output logic                                rvalid,
  input  logic                                rready,
  output logic [axi_sram_pkg::addr_width-1:0] sram_addr,
  inout  wire  [axi_sram_pkg::data_width-1:0] sram_data,
  output logic                                sram_we_n,
  output logic                                sram_oe_n,
  output logic                                sram_ce_n
);

  import axi_sram_pkg::*;

  logic                  wr_req;
  logic                  wr_grant;
  logic                  wr_done;
  sram_req_t             wr_req_data;
  logic                  rd_req;
  logic                  rd_grant;
  logic                  rd_done;
  sram_req_t             rd_req_data;
  logic                  start;
  logic                  busy;
  logic                  done;
  sram_req_t             ctrl_req;
  logic [data_width-1:0] ctrl_rdata;

  axi_sram_write_port write_port0 (
    .axi_clk    (axi_clk),
    .axi_resetn (axi_resetn),
    .awaddr     (awaddr),
    .awvalid    (awvalid),
    .awready    (awready),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .wvalid     (wvalid),
    .wready     (wready),
    .bresp      (bresp),
    .bvalid     (bvalid),
    .bready     (bready),
    .req        (wr_req),
    .req_data   (wr_req_data),
    .grant      (wr_grant),
    .done       (wr_done)
  );

  axi_sram_read_port read_port0 (
    .axi_clk    (axi_clk),
    .axi_resetn (axi_resetn),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .rdata      (rdata),
    .rresp      (rresp),
    .rvalid     (rvalid),
    .rready     (rready),
    .req        (rd_req),
    .req_data   (rd_req_data),
    .grant      (rd_grant),
    .done       (rd_done),
    .rdata_in   (ctrl_rdata)
  );

  sram_rw_arbiter arbiter0 (
    .axi_clk     (axi_clk),
    .axi_resetn  (axi_resetn),
    .wr_req      (wr_req),
    .wr_req_data (wr_req_data),
    .wr_grant    (wr_grant),
    .wr_done     (wr_done),
    .rd_req      (rd_req),
    .rd_req_data (rd_req_data),
    .rd_grant    (rd_grant),
    .rd_done     (rd_done),
    .start       (start),
    .ctrl_req    (ctrl_req),
    .busy        (busy),
    .done        (done)
  );

  sram_controller controller0 (
    .axi_clk    (axi_clk),
    .axi_resetn (axi_resetn),
    .start      (start),
    .req        (ctrl_req),
    .busy       (busy),
    .done       (done),
    .rdata      (ctrl_rdata),
    .sram_addr  (sram_addr),
    .sram_data  (sram_data),
    .sram_we_n  (sram_we_n),
    .sram_oe_n  (sram_oe_n),
    .sram_ce_n  (sram_ce_n)
  );

endmodule

// File: rtl/axi_sram_write_port.sv
`timescale 1ns/1ns

module axi_sram_write_port (
  input  logic                                axi_clk,
  input  logic                                axi_resetn,
  input  logic [axi_sram_pkg::addr_width-1:0] awaddr,
  input  logic                                awvalid,
  output logic                                awready,
  input  logic [axi_sram_pkg::data_width-1:0] wdata,
  input  logic [axi_sram_pkg::strb_width-1:0] wstrb,
  input  logic                                wvalid,
  output logic                                wready,
  output logic [1:0]                          bresp,
  output logic                                bvalid,
  input  logic                                bready,
  output logic                                req,
  output axi_sram_pkg::sram_req_t             req_data,
  input  logic                                grant,
  input  logic                                done
);

  import axi_sram_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_request,
    st_wait,
    st_respond
  } state_t;

  state_t    state;
  logic      accept;
  sram_req_t req_q;

  // aw and w are taken in the same cycle
  assign awready = accept;
  assign wready  = accept;
  assign req      = (state == st_request);
  assign req_data = req_q;

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      state  <= st_idle;
      accept <= 1'b0;
      bvalid <= 1'b0;
    end else begin
      accept <= 1'b0;
      case (state)
        st_idle: begin
          if (accept) begin
            // byte lanes are hard wired on the board, partial writes are refused
            if (&wstrb) begin
              state <= st_request;
            end else begin
              state  <= st_respond;
              bvalid <= 1'b1;
            end
          end else if (awvalid && wvalid) begin
            accept <= 1'b1;
          end
        end
        st_request: begin
          if (grant) begin
            state <= st_wait;
          end
        end
        st_wait: begin
          if (done) begin
            state  <= st_respond;
            bvalid <= 1'b1;
          end
        end
        st_respond: begin
          if (bready) begin
            bvalid <= 1'b0;
            state  <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // payload captured in the accept cycle
  always_ff @(posedge axi_clk) begin
    if (accept) begin
      req_q.write <= 1'b1;
      req_q.addr  <= awaddr;
      req_q.wdata <= wdata;
      bresp       <= (&wstrb) ? resp_okay : resp_slverr;
    end
  end

endmodule

// File: rtl/sram_controller.sv
`timescale 1ns/1ns

module sram_controller (
  input  logic                                axi_clk,
  input  logic                                axi_resetn,
  input  logic                                start,
  input  axi_sram_pkg::sram_req_t             req,
  output logic                                busy,
  output logic                                done,
  output logic [axi_sram_pkg::data_width-1:0] rdata,
  output logic [axi_sram_pkg::addr_width-1:0] sram_addr,
  inout  wire  [axi_sram_pkg::data_width-1:0] sram_data,
  output logic                                sram_we_n,
  output logic                                sram_oe_n,
  output logic                                sram_ce_n
);

  import axi_sram_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_access,
    st_finish
  } state_t;

  typedef logic [$clog2(sram_access_cycles + 1)-1:0] cnt_t;

  state_t    state;
  cnt_t      cnt;
  sram_req_t req_q;
  logic      last_cycle;

  assign last_cycle = (state == st_access) && (cnt == cnt_t'(sram_access_cycles - 1));

  assign busy      = (state != st_idle);
  assign done      = (state == st_finish);
  assign sram_addr = req_q.addr;

  // write data stays on the bus one cycle past we_n rising for hold time
  assign sram_data = (busy && req_q.write) ? req_q.wdata : 'z;

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      state     <= st_idle;
      cnt       <= '0;
      sram_ce_n <= 1'b1;
      sram_we_n <= 1'b1;
      sram_oe_n <= 1'b1;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            state     <= st_access;
            cnt       <= '0;
            sram_ce_n <= 1'b0;
            sram_we_n <= !req.write;
            sram_oe_n <= req.write;
          end
        end
        st_access: begin
          cnt <= cnt + 1'b1;
          if (last_cycle) begin
            state     <= st_finish;
            sram_ce_n <= 1'b1;
            sram_we_n <= 1'b1;
            sram_oe_n <= 1'b1;
          end
        end
        st_finish: begin
          state <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge axi_clk) begin
    if (state == st_idle && start) begin
      req_q <= req;
    end
    // sample at the end of the last oe_n low cycle
    if (last_cycle && !req_q.write) begin
      rdata <= sram_data;
    end
  end

endmodule

// File: rtl/sram_rw_arbiter.sv
`timescale 1ns/1ns

module sram_rw_arbiter (
  input  logic                    axi_clk,
  input  logic                    axi_resetn,
  input  logic                    wr_req,
  input  axi_sram_pkg::sram_req_t wr_req_data,
  output logic                    wr_grant,
  output logic                    wr_done,
  input  logic                    rd_req,
  input  axi_sram_pkg::sram_req_t rd_req_data,
  output logic                    rd_grant,
  output logic                    rd_done,
  output logic                    start,
  output axi_sram_pkg::sram_req_t ctrl_req,
  input  logic                    busy,
  input  logic                    done
);

  import axi_sram_pkg::*;

  logic pri_write;
  logic pending;
  logic owner_write;
  logic free;
  logic pick_write;

  // pending covers the start cycle itself, before busy rises
  assign free = !busy && !pending;

  // write wins when it has priority or the read port is quiet
  assign pick_write = wr_req && (pri_write || !rd_req);

  assign wr_grant = free && pick_write;
  assign rd_grant = free && rd_req && !pick_write;
  assign start    = wr_grant || rd_grant;
  assign ctrl_req = pick_write ? wr_req_data : rd_req_data;

  // done goes back only to the owner of the access
  assign wr_done = done && pending && owner_write;
  assign rd_done = done && pending && !owner_write;

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      pri_write   <= 1'b0;
      pending     <= 1'b0;
      owner_write <= 1'b0;
    end else begin
      if (start) begin
        // priority moves away from the port just served
        pri_write   <= rd_grant;
        pending     <= 1'b1;
        owner_write <= wr_grant;
      end else if (done) begin
        pending <= 1'b0;
      end
    end
  end

endmodule
